//--- hdl/acc_pkg.sv
// accumulator datapath types: machine word, register set, unit update and sequencer phase
package acc_pkg;

    localparam int WORD_W = 12;  // pdp-8 word

    // bit 0 is the msb, as in the pdp-8 manuals
    typedef logic [0:WORD_W-1] word_t;

    // architectural registers of the accumulator section
    typedef struct packed
    {
        logic  link;  // carry / rotate extension of ac
        word_t ac;
        word_t mq;    // multiplier-quotient
    } acc_state_t;

    // one proposal from a unit to the register set
    typedef struct packed
    {
        logic       we;          // load next_state at the edge
        acc_state_t next_state;
    } acc_update_t;

    // Major-state phases the accumulator reacts to. The sequencer holds each one
    // for a single clock, except EAE1 which repeats while the EAE is busy.
    typedef enum logic [3:0]
    {
        IDLE = 4'd0,
        F1   = 4'd1,  // operate: clears and complements, mq transfers
        F2   = 4'd2,  // operate: iac, group 2 cla
        F3   = 4'd3,  // operate: rotates, osr
        E1   = 4'd4,  // memory operand valid
        E2   = 4'd5,  // and / tad
        E3   = 4'd6,  // dca clear
        EAE0 = 4'd7,  // eae setup
        EAE1 = 4'd8   // eae iteration
    } phase_t;

endpackage

//--- hdl/pdp8_isa_pkg.sv
// pdp-8/e instruction encodings: opcodes, operate microinstruction bits and mode-A eae codes
package pdp8_isa_pkg;

    // opcode field, bits 0:2
    localparam logic [2:0] OP_AND = 3'o0;
    localparam logic [2:0] OP_TAD = 3'o1;
    localparam logic [2:0] OP_DCA = 3'o3;
    localparam logic [2:0] OP_OPR = 3'o7;

    // operate group select
    localparam int B_GROUP  = 3;   // 0 = group 1
    localparam int B_GROUP3 = 11;  // with B_GROUP set: 1 = group 3, 0 = group 2

    // group 1 (also CLA of group 3)
    localparam int B_CLA     = 4;
    localparam int B_CLL     = 5;
    localparam int B_CMA     = 6;
    localparam int B_CML     = 7;
    localparam int B_ROT_MSB = 8;   // rotate field is bits 8:10
    localparam int B_ROT_LSB = 10;
    localparam int B_IAC     = 11;

    // rotate field codes
    localparam logic [2:0] ROT_BSW = 3'b001;
    localparam logic [2:0] ROT_RAL = 3'b010;
    localparam logic [2:0] ROT_RTL = 3'b011;
    localparam logic [2:0] ROT_RAR = 3'b100;
    localparam logic [2:0] ROT_RTR = 3'b101;

    // group 2 and group 3
    localparam int B_G2_CLA = 4;
    localparam int B_G2_OSR = 9;
    localparam int B_G3_MQA = 5;
    localparam int B_G3_MQL = 7;

    // mode A eae, compared after masking off cla/mqa/sca/mql
    localparam logic [0:11] EAE_MASK = 12'o7417;
    localparam logic [0:11] EAE_MUL  = 12'o7405;
    localparam logic [0:11] EAE_DIV  = 12'o7407;
    localparam logic [0:11] EAE_SHL  = 12'o7413;
    localparam logic [0:11] EAE_ASR  = 12'o7415;
    localparam logic [0:11] EAE_LSR  = 12'o7417;

    localparam logic [4:0] SHIFT_LIMIT = 5'd24;  // count field that saturates
    localparam logic [4:0] MUL_STEPS   = 5'd12;
    localparam logic [4:0] DIV_STEPS   = 5'd12;

endpackage

//--- hdl/acc_regs.sv
// link, ac and mq register set, loaded from whichever unit offers an update
module acc_regs
    import acc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  acc_update_t op_update,
    input  acc_update_t mem_update,
    input  acc_update_t eae_update,
    output acc_state_t  regs
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            regs <= '0;
        end
        else if (op_update.we)
        begin
            regs <= op_update.next_state;  // operate phases
        end
        else if (mem_update.we)
        begin
            regs <= mem_update.next_state;  // execute phases
        end
        else if (eae_update.we)
        begin
            regs <= eae_update.next_state;
        end
    end

    // the three units decode disjoint phases, so two writers in a cycle
    // means the sequencer and the unit decoders disagree
    a_single_writer: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({op_update.we, mem_update.we, eae_update.we})
    )
    else $error("more than one unit writes the accumulator registers");

endmodule

//--- hdl/operate_unit.sv
// operate microinstruction datapath for groups 1, 2 and 3 over phases F1 to F3
module operate_unit
    import acc_pkg::*;
    import pdp8_isa_pkg::*;
(
    input  phase_t      phase,
    input  word_t       instruction,
    input  word_t       sr,
    input  acc_state_t  cur_state,
    output acc_update_t op_update
);

    logic        is_opr;
    logic        is_grp1;
    logic        is_grp2;
    logic        is_grp3;
    logic [0:12] inc_sum;  // link:ac + 1
    word_t       g3_ac;    // ac after the group 3 cla

    assign is_opr  = (instruction[0:2] == OP_OPR);
    assign is_grp1 = is_opr && !instruction[B_GROUP];
    assign is_grp2 = is_opr && instruction[B_GROUP] && !instruction[B_GROUP3];
    assign is_grp3 = is_opr && instruction[B_GROUP] && instruction[B_GROUP3];

    assign inc_sum = {cur_state.link, cur_state.ac} + 13'd1;
    assign g3_ac   = instruction[B_CLA] ? '0 : cur_state.ac;

    always_comb
    begin
        op_update.we         = 1'b0;
        op_update.next_state = cur_state;
        case (phase)
            F1:
            begin
                if (is_grp1)
                begin
                    op_update.we = 1'b1;
                    // clears act before complements
                    if (instruction[B_CLA])
                        op_update.next_state.ac = '0;
                    if (instruction[B_CLL])
                        op_update.next_state.link = 1'b0;
                    if (instruction[B_CMA])
                        op_update.next_state.ac = ~op_update.next_state.ac;
                    if (instruction[B_CML])
                        op_update.next_state.link = ~op_update.next_state.link;
                end
                else if (is_grp3)
                begin
                    // mqa+mql is swp, cla+mql is cam, cla+mqa is acl
                    op_update.we            = 1'b1;
                    op_update.next_state.ac = (instruction[B_G3_MQA] ? cur_state.mq : '0) |
                                              (instruction[B_G3_MQL] ? '0 : g3_ac);
                    if (instruction[B_G3_MQL])
                        op_update.next_state.mq = g3_ac;  // ac moves into mq
                end
            end
            F2:
            begin
                if (is_grp1)
                begin
                    op_update.we = 1'b1;
                    if (instruction[B_IAC])
                        {op_update.next_state.link, op_update.next_state.ac} = inc_sum;
                end
                else if (is_grp2)
                begin
                    op_update.we = 1'b1;
                    if (instruction[B_G2_CLA])
                        op_update.next_state.ac = '0;  // ahead of osr in F3
                end
            end
            F3:
            begin
                if (is_grp1)
                begin
                    op_update.we = 1'b1;
                    case (instruction[B_ROT_MSB:B_ROT_LSB])
                        ROT_BSW: op_update.next_state.ac = {cur_state.ac[6:11], cur_state.ac[0:5]};
                        ROT_RAL: {op_update.next_state.link, op_update.next_state.ac} =
                                     {cur_state.ac, cur_state.link};
                        ROT_RTL: {op_update.next_state.link, op_update.next_state.ac} =
                                     {cur_state.ac[1:11], cur_state.link, cur_state.ac[0]};
                        ROT_RAR: {op_update.next_state.link, op_update.next_state.ac} =
                                     {cur_state.ac[11], cur_state.link, cur_state.ac[0:10]};
                        ROT_RTR: {op_update.next_state.link, op_update.next_state.ac} =
                                     {cur_state.ac[10:11], cur_state.link, cur_state.ac[0:9]};
                        default: ;  // no rotate
                    endcase
                end
                else if (is_grp2)
                begin
                    op_update.we = 1'b1;
                    if (instruction[B_G2_OSR])
                        op_update.next_state.ac = cur_state.ac | sr;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/memref_unit.sv
// memory reference execute datapath for and, tad and dca
module memref_unit
    import acc_pkg::*;
    import pdp8_isa_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  phase_t      phase,
    input  word_t       instruction,
    input  word_t       mdout,
    input  acc_state_t  cur_state,
    output acc_update_t mem_update
);

    word_t       operand;   // memory word captured in E1
    logic [0:12] tad_sum;   // carry:sum

    always_ff @(posedge clk)
    begin
        if (phase == E1)
            operand <= mdout;
    end

    assign tad_sum = {1'b0, cur_state.ac} + {1'b0, operand};

    always_comb
    begin
        mem_update.we         = 1'b0;
        mem_update.next_state = cur_state;
        if ((phase == E2) && (instruction[0:2] == OP_AND))
        begin
            mem_update.we            = 1'b1;
            mem_update.next_state.ac = cur_state.ac & operand;
        end
        else if ((phase == E2) && (instruction[0:2] == OP_TAD))
        begin
            mem_update.we              = 1'b1;
            mem_update.next_state.ac   = tad_sum[1:12];
            mem_update.next_state.link = cur_state.link ^ tad_sum[0];  // carry flips link
        end
        else if ((phase == E3) && (instruction[0:2] == OP_DCA))
        begin
            mem_update.we            = 1'b1;
            mem_update.next_state.ac = '0;  // memory side stores ac
        end
    end

    // the operand register is only valid if E1 came right before
    a_e2_after_e1: assert property (
        @(posedge clk) disable iff (reset)
        (phase == E2) |-> ($past(phase) == E1)
    )
    else $error("execute phase E2 without a preceding E1");

endmodule

//--- hdl/eae_unit.sv
// mode-A extended arithmetic element: multiply, divide and shifts with a step counter
module eae_unit
    import acc_pkg::*;
    import pdp8_isa_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  phase_t      phase,
    input  word_t       instruction,
    input  word_t       mdout,
    input  acc_state_t  cur_state,
    output acc_update_t eae_update,
    output logic        eae_busy
);

    word_t       eae_code;     // instruction with non-eae bits masked
    logic [4:0]  sc;           // step counter
    logic [4:0]  sc_next;
    logic        busy_next;
    logic [4:0]  shift_field;  // count field of the operand
    word_t       mul_addend;
    logic [0:12] mul_sum;
    logic [0:13] div_trial;    // borrow in bit 0
    logic        div_ovf;

    assign eae_code    = instruction & EAE_MASK;
    assign shift_field = mdout[7:11];

    // multiply adds mdout when the low multiplier bit is set
    assign mul_addend = cur_state.mq[11] ? mdout : '0;
    assign mul_sum    = {1'b0, cur_state.ac} + {1'b0, mul_addend};

    // restoring divide, trial subtract of the divisor from ac:mq[0]
    assign div_trial = {1'b0, cur_state.ac, cur_state.mq[0]} - {2'b00, mdout};
    assign div_ovf   = (cur_state.ac >= mdout);

    always_comb
    begin
        eae_update.we         = 1'b0;
        eae_update.next_state = cur_state;
        sc_next               = sc;
        busy_next             = eae_busy;
        case (phase)
            EAE0:
            begin
                case (eae_code)
                    EAE_MUL:
                    begin
                        eae_update.we              = 1'b1;
                        eae_update.next_state.link = 1'b0;
                        sc_next                    = MUL_STEPS;
                        busy_next                  = 1'b1;
                    end
                    EAE_DIV:
                    begin
                        eae_update.we = 1'b1;
                        if (div_ovf)
                        begin
                            eae_update.next_state.link = 1'b1;  // quotient too big
                        end
                        else
                        begin
                            eae_update.next_state.link = 1'b0;
                            sc_next                    = DIV_STEPS;
                            busy_next                  = 1'b1;
                        end
                    end
                    EAE_SHL, EAE_ASR, EAE_LSR:
                    begin
                        eae_update.we = 1'b1;
                        if (shift_field >= SHIFT_LIMIT)
                        begin
                            // everything shifted out, only the sign is left
                            if ((eae_code == EAE_ASR) && cur_state.ac[0])
                                eae_update.next_state = '1;
                            else
                                eae_update.next_state = '0;
                        end
                        else
                        begin
                            // asr shifts the sign in through the link
                            eae_update.next_state.link = (eae_code == EAE_ASR) ?
                                                         cur_state.ac[0] : 1'b0;
                            sc_next                    = shift_field + 5'd1;
                            busy_next                  = 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            EAE1:
            begin
                if (eae_busy)
                begin
                    eae_update.we = 1'b1;
                    sc_next       = sc - 5'd1;
                    if (sc == 5'd1)
                        busy_next = 1'b0;  // last step
                    case (eae_code)
                        EAE_MUL:
                            {eae_update.next_state.ac, eae_update.next_state.mq} =
                                {mul_sum, cur_state.mq[0:10]};
                        EAE_DIV:
                        begin
                            if (!div_trial[0])
                            begin
                                eae_update.next_state.ac = div_trial[2:13];
                                eae_update.next_state.mq = {cur_state.mq[1:11], 1'b1};
                            end
                            else
                            begin
                                eae_update.next_state.ac = {cur_state.ac[1:11], cur_state.mq[0]};
                                eae_update.next_state.mq = {cur_state.mq[1:11], 1'b0};
                            end
                        end
                        EAE_SHL:
                            eae_update.next_state = {cur_state.ac, cur_state.mq, 1'b0};
                        EAE_ASR, EAE_LSR:
                            {eae_update.next_state.ac, eae_update.next_state.mq} =
                                {cur_state.link, cur_state.ac, cur_state.mq[0:10]};
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sc       <= '0;
            eae_busy <= 1'b0;
        end
        else
        begin
            sc       <= sc_next;
            eae_busy <= busy_next;
        end
    end

    // the sequencer only enters EAE1 after a setup in EAE0
    a_busy_from_setup: assert property (
        @(posedge clk) disable iff (reset)
        $rose(eae_busy) |-> ($past(phase) == EAE0)
    )
    else $error("eae_busy rose outside the EAE0 setup phase");

endmodule

//--- hdl/accumulator.sv
// accumulator section top: register set plus operate, memory reference and eae units
module accumulator
    import acc_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  phase_t     phase,
    input  word_t      instruction,
    input  word_t      mdout,
    input  word_t      sr,
    output acc_state_t regs,
    output logic       eae_busy
);

    acc_state_t  cur_state;  // register contents fed back to the units
    acc_update_t op_update;
    acc_update_t mem_update;
    acc_update_t eae_update;

    assign regs = cur_state;

    acc_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .op_update  (op_update),
        .mem_update (mem_update),
        .eae_update (eae_update),
        .regs       (cur_state)
    );

    operate_unit u_operate (
        .phase       (phase),
        .instruction (instruction),
        .sr          (sr),
        .cur_state   (cur_state),
        .op_update   (op_update)
    );

    memref_unit u_memref (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .instruction (instruction),
        .mdout       (mdout),
        .cur_state   (cur_state),
        .mem_update  (mem_update)
    );

    eae_unit u_eae (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .instruction (instruction),
        .mdout       (mdout),
        .cur_state   (cur_state),
        .eae_update  (eae_update),
        .eae_busy    (eae_busy)
    );

endmodule

//--- include/tb_tasks.svh
// testbench tasks that run each instruction's phase sequence, with the reference arithmetic
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// one sequencer phase held for a single clock
task automatic run_phase(input phase_t p);
    phase = p;
    @(posedge clk);
    #1;
    phase = IDLE;
endtask

function automatic acc_state_t random_state();
    return acc_state_t'(25'($urandom));
endfunction

// link:ac as one 13-bit ring, link on top
function automatic acc_state_t rotate_ref(input acc_state_t s, input logic [2:0] rot);
    logic [12:0] v;
    v = {s.link, s.ac};
    case (rot)
        ROT_BSW: v[11:0] = {v[5:0], v[11:6]};  // halves of ac swap
        ROT_RAL: v = {v[11:0], v[12]};
        ROT_RTL: v = {v[10:0], v[12:11]};
        ROT_RAR: v = {v[0], v[12:1]};
        ROT_RTR: v = {v[1:0], v[12:2]};
        default: ;
    endcase
    {s.link, s.ac} = v;
    return s;
endfunction

function automatic acc_state_t eae_ref(input acc_state_t s, input word_t code, input word_t d);
    logic [23:0] acmq;
    logic [11:0] dd;
    int          n;
    acmq = {s.ac, s.mq};
    dd   = d;
    n    = dd[4:0] + 1;  // shift distance
    case (code)
        EAE_MUL:
        begin
            acmq   = 24'(s.mq) * 24'(d) + 24'(s.ac);
            s.link = 1'b0;
        end
        EAE_DIV:
        begin
            s.link = (s.ac >= d);  // overflow keeps ac and mq
            if (!s.link)
                acmq = {12'(acmq % dd), 12'(acmq / dd)};
        end
        EAE_SHL:
            {s.link, acmq} = {1'b0, acmq} << n;
        EAE_ASR:
        begin
            s.link = s.ac[0];  // sign
            acmq   = $signed(acmq) >>> n;
        end
        EAE_LSR:
        begin
            s.link = 1'b0;
            acmq   = acmq >> n;
        end
        default: ;
    endcase
    {s.ac, s.mq} = acmq;
    return s;
endfunction

// operate word through F1 to F3, checked after each phase
task automatic run_operate(input word_t instr);
    acc_state_t  exp;
    logic [11:0] w;       // w[n] carries octal weight 2**n
    word_t       cla_ac;
    logic        g1;
    logic        g2;
    string       grp;
    w           = instr;
    g1          = !w[8];
    g2          = w[8] && !w[0];
    grp         = g1 ? "group1" : (g2 ? "group2" : "group3");
    instruction = instr;
    exp         = regs;
    cla_ac      = w[7] ? '0 : exp.ac;
    if (g1)
    begin
        exp.ac   = cla_ac ^ {12{w[5]}};  // cla, then cma
        exp.link = (w[6] ? 1'b0 : exp.link) ^ w[4];
    end
    else if (!g2 && w[4] && w[6])
    begin
        exp.ac = exp.mq;  // swp
        exp.mq = cla_ac;
    end
    else if (!g2 && w[4])
    begin
        exp.mq = cla_ac;  // mql, or cam with cla
        exp.ac = '0;
    end
    else if (!g2)
        exp.ac = w[6] ? (cla_ac | exp.mq) : cla_ac;
    run_phase(F1);
    check_regs({grp, " F1"}, exp);
    if (g1)
        {exp.link, exp.ac} = {exp.link, exp.ac} + 13'(w[0]);  // iac
    else if (g2)
        exp.ac = w[7] ? '0 : exp.ac;
    run_phase(F2);
    check_regs({grp, " F2"}, exp);
    if (g1)
        exp = rotate_ref(exp, w[3:1]);
    else if (g2)
        exp.ac = w[2] ? (exp.ac | sr) : exp.ac;  // osr
    run_phase(F3);
    check_regs({grp, " F3"}, exp);
endtask

task automatic run_memref(input word_t instr, input word_t operand, input string name);
    acc_state_t  exp;
    logic [12:0] sum;
    exp         = regs;
    instruction = instr;
    mdout       = operand;
    run_phase(E1);
    mdout = 12'($urandom);  // operand now only in the latch
    sum   = {1'b0, exp.ac} + {1'b0, operand};
    if (instr[0:2] == OP_AND)
        exp.ac = exp.ac & operand;
    else if (instr[0:2] == OP_TAD)
        {exp.link, exp.ac} = {exp.link ^ sum[12], sum[11:0]};
    run_phase(E2);
    check_regs({name, " E2"}, exp);
    if (instr[0:2] == OP_DCA)
        exp.ac = '0;
    run_phase(E3);
    check_regs({name, " E3"}, exp);
endtask

task automatic run_eae(input word_t code, input word_t operand, input string name);
    acc_state_t exp;
    int         cycles;
    exp         = eae_ref(regs, code, operand);
    instruction = code;
    mdout       = operand;
    run_phase(EAE0);
    cycles = 0;
    while (eae_busy)
    begin
        if (cycles > SHIFT_LIMIT + 8)
            stop_on_error($sformatf("%s: eae_busy still high after %0d cycles", name, cycles));
        run_phase(EAE1);
        cycles++;
    end
    check_regs(name, exp);
endtask

// reaches any link, ac, mq through cla cll, tad, mql and cml
task automatic load_state(input acc_state_t s);
    run_operate(12'o7300);
    run_memref({OP_TAD, 9'o0}, s.mq, "load TAD");
    run_operate(12'o7421);
    run_memref({OP_TAD, 9'o0}, s.ac, "load TAD");
    if (s.link)
        run_operate(12'o7020);
endtask

`endif

//--- verif/accumulator_tb.sv
// testbench for the accumulator section that steps the sequencer phases and checks link, ac and mq
module accumulator_tb
    import acc_pkg::*;
    import pdp8_isa_pkg::*;
();

    logic       clk;
    logic       reset;
    phase_t     phase;
    word_t      instruction;
    word_t      mdout;
    word_t      sr;
    acc_state_t regs;
    logic       eae_busy;

    accumulator uut (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .instruction (instruction),
        .mdout       (mdout),
        .sr          (sr),
        .regs        (regs),
        .eae_busy    (eae_busy)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;  // period of 8

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // registers against the value worked out from the instruction rules
    task automatic check_regs(input string name, input acc_state_t exp);
        assert (regs === exp)
        else
            stop_on_error($sformatf("Fail %s expected %b/%o/%o actual %b/%o/%o", name,
                                    exp.link, exp.ac, exp.mq, regs.link, regs.ac, regs.mq));
    endtask

    `include "tb_tasks.svh"

    initial
    begin
        acc_state_t  s;
        word_t       d;
        logic [11:0] w;
        int          k;
        void'($urandom(16460));
        reset       = 1'b1;
        phase       = IDLE;
        instruction = '0;
        mdout       = '0;
        sr          = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_regs("reset", '0);
        assert (eae_busy === 1'b0)
        else
            stop_on_error("eae_busy is high right after reset");

        // group 1, then group 2 against random switches
        repeat (64)
        begin
            load_state(random_state());
            sr = 12'($urandom);
            run_operate(12'o7000 | (12'($urandom) & 12'o0377));
            run_operate(12'o7400 | (12'($urandom) & 12'o0376));
        end

        // every cla, mqa and mql combination
        for (k = 0; k < 32; k++)
        begin
            w    = 12'o7401 | (12'($urandom) & 12'o0056);
            w[7] = k[0];  // cla
            w[6] = k[1];  // mqa
            w[4] = k[2];  // mql
            load_state(random_state());
            run_operate(w);
        end

        repeat (48)
        begin
            load_state(random_state());
            run_memref({OP_AND, 9'($urandom)}, 12'($urandom), "AND");
            run_memref({OP_TAD, 9'($urandom)}, 12'($urandom), "TAD");
            run_memref({OP_DCA, 9'($urandom)}, 12'($urandom), "DCA");
        end

        repeat (32)
        begin
            load_state(random_state());
            run_eae(EAE_MUL, 12'($urandom), "MUL");
            s    = random_state();
            d    = 12'($urandom % 4095) + 12'd1;
            s.ac = 12'(s.ac % d);  // below the divisor
            load_state(s);
            run_eae(EAE_DIV, d, "DIV");
            s = random_state();
            d = 12'($urandom % (s.ac + 1));  // divisor not above ac
            load_state(s);
            run_eae(EAE_DIV, d, "DIV overflow");
        end

        repeat (32)
        begin
            load_state(random_state());
            run_eae(EAE_SHL, 12'($urandom), "SHL");
            load_state(random_state());
            run_eae(EAE_LSR, 12'($urandom), "LSR");
            load_state(random_state());
            run_eae(EAE_ASR, 12'($urandom), "ASR");
        end

        // counts at and past the limit on a negative ac
        s       = random_state();
        s.ac[0] = 1'b1;
        load_state(s);
        run_eae(EAE_ASR, 12'o0030, "ASR at limit");
        load_state(s);
        run_eae(EAE_SHL, 12'o0037, "SHL past limit");
        load_state(s);
        run_eae(EAE_LSR, 12'o0031, "LSR past limit");

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
hdl/acc_pkg.sv
hdl/pdp8_isa_pkg.sv
hdl/acc_regs.sv
hdl/operate_unit.sv
hdl/memref_unit.sv
hdl/eae_unit.sv
hdl/accumulator.sv
verif/accumulator_tb.sv
